/* include/osf_defs.svh */
`ifndef OSF_DEFS_SVH
`define OSF_DEFS_SVH

// ----------------------------------------------------------
// Channel layout
// ----------------------------------------------------------
// Channels per ADC frame
`define OSF_N_CHAN 8
// Channel index width
`define OSF_W_CHAN 3

// ----------------------------------------------------------
// Data path widths
// ----------------------------------------------------------
// Signed ADC sample
`define OSF_W_DATA 18
// Accumulator, narrow enough to hit saturation
`define OSF_W_SUM 24
// Oversample exponent, ratio 1 to 128
`define OSF_W_OS 3
// Sample count, wide enough to hold 2^(2^W_OS - 1)
`define OSF_W_COUNT (1 << `OSF_W_OS)

// ----------------------------------------------------------
// Register write bus
// ----------------------------------------------------------
`define OSF_W_ADDR 16
`define OSF_W_WDATA 32
// Per-channel oversample exponent
`define OSF_ADDR_OS 16'h0010
// Per-channel clear request, bit 0
`define OSF_ADDR_CLR 16'h0011

`endif

/* src/osf_pkg.sv */
`include "osf_defs.svh"

package osf_pkg;

    // ----------------------------------------------------------
    // Width types
    // ----------------------------------------------------------
    typedef logic [`OSF_W_CHAN-1:0] chan_t;
    typedef logic signed [`OSF_W_DATA-1:0] sample_t;
    typedef logic signed [`OSF_W_SUM-1:0] sum_t;
    typedef logic [`OSF_W_OS-1:0] os_t;
    typedef logic [`OSF_W_COUNT-1:0] count_t;
    typedef logic [`OSF_W_ADDR-1:0] reg_addr_t;
    typedef logic [`OSF_W_WDATA-1:0] reg_wdata_t;

    // ----------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------
    // One tagged sample, used for stream, avg and results
    typedef struct packed {
        logic valid;
        chan_t chan;
        sample_t data;
    } chan_sample_t;

    // Register write strobe bus
    // chan is a full-width register field, range checked by the decoder
    typedef struct packed {
        logic en;
        reg_addr_t addr;
        reg_addr_t chan;
        reg_wdata_t data;
    } reg_wr_t;

    // Parallel ADC frame, element c belongs to channel c
    typedef sample_t [`OSF_N_CHAN-1:0] frame_t;

endpackage

/* src/frame_serializer.sv */
`include "osf_defs.svh"

module frame_serializer (
    input  logic clk_in,
    input  logic arst_n,
    input  logic frame_valid,
    input  osf_pkg::frame_t frame,
    output osf_pkg::chan_sample_t stream
);

    localparam osf_pkg::chan_t LAST_CHAN = osf_pkg::chan_t'(`OSF_N_CHAN - 1);

    // ----------------------------------------------------------
    // State
    // ----------------------------------------------------------
    osf_pkg::frame_t frame_q;
    logic busy;
    // Next channel to emit while busy
    osf_pkg::chan_t cnt;

    logic stream_valid;
    osf_pkg::chan_t stream_chan;
    osf_pkg::sample_t stream_data;

    // Channel 0 goes out straight from the incoming frame
    // Strobes during busy are dropped
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt <= '0;
            stream_valid <= 1'b0;
            stream_chan <= '0;
        end else if (busy) begin
            stream_valid <= 1'b1;
            stream_chan <= cnt;
            cnt <= cnt + 1'b1;
            // Last channel out, ready for next frame
            if (cnt == LAST_CHAN) begin
                busy <= 1'b0;
            end
        end else if (frame_valid) begin
            stream_valid <= 1'b1;
            stream_chan <= '0;
            cnt <= osf_pkg::chan_t'(1);
            busy <= 1'b1;
        end else begin
            stream_valid <= 1'b0;
        end
    end

    // Sample payload
    always_ff @(posedge clk_in) begin
        if (busy) begin
            stream_data <= frame_q[cnt];
        end else if (frame_valid) begin
            frame_q <= frame;
            stream_data <= frame[0];
        end
    end

    assign stream = '{valid: stream_valid, chan: stream_chan, data: stream_data};

endmodule

/* src/chan_config_regs.sv */
`include "osf_defs.svh"

module chan_config_regs (
    input  logic clk_in,
    input  logic arst_n,
    input  osf_pkg::reg_wr_t reg_wr,
    output osf_pkg::os_t [`OSF_N_CHAN-1:0] os_ratio,
    output logic [`OSF_N_CHAN-1:0] clr_mask
);

    // ----------------------------------------------------------
    // Write decode
    // ----------------------------------------------------------
    logic chan_ok;
    logic wr_ok;
    osf_pkg::chan_t wr_chan;

    // Channel field is 16 bits wide on the bus
    assign chan_ok = (reg_wr.chan < `OSF_N_CHAN);
    assign wr_ok = reg_wr.en && chan_ok;
    // Low bits only, upper bits already checked
    assign wr_chan = reg_wr.chan[`OSF_W_CHAN-1:0];

    // ----------------------------------------------------------
    // Ratio and clear registers
    // ----------------------------------------------------------
    // Ratio holds until rewritten
    // Clear bit lives for one cycle only
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            os_ratio <= '0;
            clr_mask <= '0;
        end else begin
            // Self-clear by default
            clr_mask <= '0;
            if (wr_ok) begin
                case (reg_wr.addr)
                    `OSF_ADDR_OS: begin
                        // Exponent k, ratio 2^k
                        os_ratio[wr_chan] <= reg_wr.data[`OSF_W_OS-1:0];
                    end
                    `OSF_ADDR_CLR: begin
                        // Only bit 0 requests a clear
                        clr_mask[wr_chan] <= reg_wr.data[0];
                    end
                    default: begin
                        // Unmapped address, no effect
                    end
                endcase
            end
        end
    end

endmodule

/* src/oversample_filter.sv */
`include "osf_defs.svh"

module oversample_filter (
    input  logic clk_in,
    input  logic arst_n,
    input  osf_pkg::chan_sample_t stream,
    input  osf_pkg::os_t [`OSF_N_CHAN-1:0] os_ratio,
    input  logic [`OSF_N_CHAN-1:0] clr_mask,
    output osf_pkg::chan_sample_t avg
);

    // Saturation limits of the accumulator
    localparam osf_pkg::sum_t SUM_MAX = {1'b0, {(`OSF_W_SUM - 1){1'b1}}};
    localparam osf_pkg::sum_t SUM_MIN = {1'b1, {(`OSF_W_SUM - 1){1'b0}}};

    // ----------------------------------------------------------
    // Per-channel sum and count
    // ----------------------------------------------------------
    osf_pkg::sum_t sum_mem [`OSF_N_CHAN];
    osf_pkg::count_t count_mem [`OSF_N_CHAN];

    // ----------------------------------------------------------
    // Stage 1 fetch
    // ----------------------------------------------------------
    logic v1;
    osf_pkg::chan_t chan1;
    osf_pkg::sample_t din1;
    osf_pkg::sum_t sum1;
    osf_pkg::count_t cnt1;

    // Sample arriving with its clear is dropped
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            v1 <= 1'b0;
        end else begin
            v1 <= stream.valid && !clr_mask[stream.chan];
        end
    end

    // No forwarding needed
    // Same channel returns only after N_CHAN cycles
    always_ff @(posedge clk_in) begin
        chan1 <= stream.chan;
        din1 <= stream.data;
        sum1 <= sum_mem[stream.chan];
        cnt1 <= count_mem[stream.chan];
    end

    // ----------------------------------------------------------
    // Stage 2 accumulate
    // ----------------------------------------------------------
    // One guard bit over the sum
    logic signed [`OSF_W_SUM:0] sum_wide;
    osf_pkg::sum_t sum_sat;

    always_comb begin
        sum_wide = sum1 + din1;
        // Clamp to signed range
        if (sum_wide > SUM_MAX) begin
            sum_sat = SUM_MAX;
        end else if (sum_wide < SUM_MIN) begin
            sum_sat = SUM_MIN;
        end else begin
            sum_sat = sum_wide[`OSF_W_SUM-1:0];
        end
    end

    logic v2;
    osf_pkg::chan_t chan2;
    osf_pkg::sum_t sum2;
    osf_pkg::count_t cnt2;
    osf_pkg::os_t os2;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            v2 <= 1'b0;
        end else begin
            v2 <= v1 && !clr_mask[chan1];
        end
    end

    always_ff @(posedge clk_in) begin
        chan2 <= chan1;
        sum2 <= sum_sat;
        cnt2 <= cnt1 + 1'b1;
        // Ratio read late so a fresh write applies to this sample
        os2 <= os_ratio[chan1];
    end

    // ----------------------------------------------------------
    // Stage 3 shift and writeback
    // ----------------------------------------------------------
    logic wb_en;
    logic group_done;
    osf_pkg::sum_t sum_shift;

    assign wb_en = v2 && !clr_mask[chan2];
    // Group complete at exactly 2^k samples
    assign group_done = (cnt2 == (osf_pkg::count_t'(1) << os2));
    // Arithmetic shift, sign kept
    assign sum_shift = sum2 >>> os2;

    logic avg_valid;
    osf_pkg::chan_t avg_chan;
    osf_pkg::sample_t avg_data;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            avg_valid <= 1'b0;
        end else begin
            // Only the completing sample produces output
            avg_valid <= wb_en && group_done;
        end
    end

    always_ff @(posedge clk_in) begin
        avg_chan <= chan2;
        // Truncate to sample width
        avg_data <= sum_shift[`OSF_W_DATA-1:0];
    end

    // Writeback and clear of the channel memory
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `OSF_N_CHAN; i++) begin
                sum_mem[i] <= '0;
                count_mem[i] <= '0;
            end
        end else begin
            if (wb_en) begin
                // Restart group after output
                sum_mem[chan2] <= group_done ? '0 : sum2;
                count_mem[chan2] <= group_done ? '0 : cnt2;
            end
            // Clear wins over writeback
            for (int i = 0; i < `OSF_N_CHAN; i++) begin
                if (clr_mask[i]) begin
                    sum_mem[i] <= '0;
                    count_mem[i] <= '0;
                end
            end
        end
    end

    assign avg = '{valid: avg_valid, chan: avg_chan, data: avg_data};

endmodule

/* src/result_store.sv */
`include "osf_defs.svh"

module result_store (
    input  logic clk_in,
    input  logic arst_n,
    input  osf_pkg::chan_sample_t avg,
    input  logic rd_en,
    input  osf_pkg::chan_t rd_chan,
    output osf_pkg::sample_t rd_data,
    output logic rd_fresh,
    output logic rd_valid
);

    // ----------------------------------------------------------
    // Latest result per channel
    // ----------------------------------------------------------
    osf_pkg::sample_t avg_mem [`OSF_N_CHAN];
    logic [`OSF_N_CHAN-1:0] fresh;

    // New result sets fresh
    // Read clears it unless a result lands in the same cycle
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `OSF_N_CHAN; i++) begin
                avg_mem[i] <= '0;
            end
            fresh <= '0;
            rd_data <= '0;
            rd_fresh <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en) begin
                // Registered read, returns the old value on a collision
                rd_data <= avg_mem[rd_chan];
                rd_fresh <= fresh[rd_chan];
                fresh[rd_chan] <= 1'b0;
            end
            if (avg.valid) begin
                avg_mem[avg.chan] <= avg.data;
                fresh[avg.chan] <= 1'b1;
            end
        end
    end

endmodule

/* src/osf_top.sv */
`include "osf_defs.svh"

module osf_top (
    input  logic clk_in,
    input  logic arst_n,
    input  logic frame_valid,
    input  osf_pkg::frame_t frame,
    input  osf_pkg::reg_wr_t reg_wr,
    input  logic rd_en,
    input  osf_pkg::chan_t rd_chan,
    output osf_pkg::chan_sample_t avg,
    output osf_pkg::sample_t rd_data,
    output logic rd_fresh,
    output logic rd_valid
);

    // ----------------------------------------------------------
    // Internal nets
    // ----------------------------------------------------------
    osf_pkg::chan_sample_t stream;
    osf_pkg::os_t [`OSF_N_CHAN-1:0] os_ratio;
    logic [`OSF_N_CHAN-1:0] clr_mask;

    // Frame to per-channel stream, channel c after c+1 cycles
    frame_serializer frame_serializer_inst (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .frame_valid (frame_valid),
        .frame       (frame),
        .stream      (stream)
    );

    // Ratio and clear registers
    chan_config_regs chan_config_regs_inst (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .reg_wr   (reg_wr),
        .os_ratio (os_ratio),
        .clr_mask (clr_mask)
    );

    // Three-stage averaging pipeline
    oversample_filter oversample_filter_inst (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .stream   (stream),
        .os_ratio (os_ratio),
        .clr_mask (clr_mask),
        .avg      (avg)
    );

    // Read-back of the latest averages
    result_store result_store_inst (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .avg      (avg),
        .rd_en    (rd_en),
        .rd_chan  (rd_chan),
        .rd_data  (rd_data),
        .rd_fresh (rd_fresh),
        .rd_valid (rd_valid)
    );

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD_NS = 8,
    parameter int RST_CYCLES = 3
) (
    output logic clk_in,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock, starts low
    initial begin
        clk_in = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_in = ~clk_in;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
    end

endmodule

/* testbench/osf_tb.sv */
`include "osf_defs.svh"

module osf_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CHAN = `OSF_N_CHAN;
    localparam int N_TESTS = 7;
    localparam int FRAME_GAP = `OSF_N_CHAN + 2;
    localparam longint SUM_HI = (longint'(1) << (`OSF_W_SUM - 1)) - 1;
    localparam longint SUM_LO = -(longint'(1) << (`OSF_W_SUM - 1));

    typedef enum int {PAT_CONST, PAT_RAMP, PAT_RAND} pattern_t;

    // One row per test, clr_chan -1 means no clear
    typedef struct {
        string name;
        osf_pkg::os_t [`OSF_N_CHAN-1:0] os;
        int frames;
        pattern_t pat;
        int base;
        int clr_chan;
        int clr_frame;
        bit bad_wr;
        bit readback;
    } test_row_t;

    test_row_t tests [N_TESTS];

    // ----------------------------------------------------------
    // DUT and clock
    // ----------------------------------------------------------
    logic clk_in;
    logic arst_n;
    logic frame_valid;
    osf_pkg::frame_t frame;
    osf_pkg::reg_wr_t reg_wr;
    logic rd_en;
    osf_pkg::chan_t rd_chan;
    osf_pkg::chan_sample_t avg;
    osf_pkg::sample_t rd_data;
    logic rd_fresh;
    logic rd_valid;

    tb_clock_gen #(.PERIOD_NS(8), .RST_CYCLES(3)) tb_clock_gen_inst (
        .clk_in (clk_in),
        .arst_n (arst_n)
    );

    osf_top osf_top_inst (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .frame_valid (frame_valid),
        .frame       (frame),
        .reg_wr      (reg_wr),
        .rd_en       (rd_en),
        .rd_chan     (rd_chan),
        .avg         (avg),
        .rd_data     (rd_data),
        .rd_fresh    (rd_fresh),
        .rd_valid    (rd_valid)
    );

    // ----------------------------------------------------------
    // Reference model state
    // ----------------------------------------------------------
    longint model_sum [N_CHAN];
    int model_cnt [N_CHAN];
    int model_os [N_CHAN];
    osf_pkg::sample_t store_val [N_CHAN];
    bit store_fresh [N_CHAN];
    osf_pkg::chan_sample_t exp_q [$];
    string cur_test = "reset";
    int err_count = 0;
    int check_count = 0;
    longint watchdog_ns = 0;
    integer seed = 32'h40f19e6b;

    task automatic check_avg(osf_pkg::chan_sample_t exp_item, osf_pkg::chan_sample_t act_item);
        check_count++;
        if (act_item !== exp_item) begin
            err_count++;
            $display("ERROR %s: avg expected chan %0d data %0d, actual chan %0d data %0d",
                     cur_test, exp_item.chan, exp_item.data, act_item.chan, act_item.data);
        end
    endtask

    task automatic check_sample(string what, osf_pkg::sample_t exp_val, osf_pkg::sample_t act_val);
        check_count++;
        if (act_val !== exp_val) begin
            err_count++;
            $display("ERROR %s: %s expected %0d, actual %0d", cur_test, what, exp_val, act_val);
        end
    endtask

    task automatic check_flag(string what, logic exp_val, logic act_val);
        check_count++;
        if (act_val !== exp_val) begin
            err_count++;
            $display("ERROR %s: %s expected %b, actual %b", cur_test, what, exp_val, act_val);
        end
    endtask

    // One cycle, then 1 ns into it
    task automatic step();
        @(posedge clk_in);
        #1;
    endtask

    // Accumulate with clamp, emit on the 2^k-th sample
    task automatic model_sample(int c, osf_pkg::sample_t s);
        longint acc;
        osf_pkg::chan_sample_t item;
        acc = model_sum[c] + longint'(s);
        if (acc > SUM_HI) begin
            acc = SUM_HI;
        end else if (acc < SUM_LO) begin
            acc = SUM_LO;
        end
        model_sum[c] = acc;
        model_cnt[c]++;
        if (model_cnt[c] == (1 << model_os[c])) begin
            item.valid = 1'b1;
            item.chan = osf_pkg::chan_t'(c);
            item.data = osf_pkg::sample_t'(acc >>> model_os[c]);
            exp_q.push_back(item);
            store_val[c] = item.data;
            store_fresh[c] = 1'b1;
            model_sum[c] = 0;
            model_cnt[c] = 0;
        end
    endtask

    task automatic write_reg(osf_pkg::reg_addr_t addr, osf_pkg::reg_addr_t chan,
                             osf_pkg::reg_wdata_t data);
        reg_wr = '{en: 1'b1, addr: addr, chan: chan, data: data};
        step();
        reg_wr.en = 1'b0;
    endtask

    // Out-of-range channel field must leave the model untouched
    task automatic clear_chan(int c);
        write_reg(`OSF_ADDR_CLR, osf_pkg::reg_addr_t'(c), 1);
        if (c < N_CHAN) begin
            model_sum[c] = 0;
            model_cnt[c] = 0;
        end
        step();
    endtask

    task automatic send_frame(int t, int f);
        osf_pkg::sample_t s;
        for (int c = 0; c < N_CHAN; c++) begin
            case (tests[t].pat)
                PAT_CONST: s = osf_pkg::sample_t'(tests[t].base);
                PAT_RAMP: s = osf_pkg::sample_t'(tests[t].base + f * N_CHAN + c * 37);
                default: s = osf_pkg::sample_t'($random(seed));
            endcase
            frame[c] = s;
            model_sample(c, s);
        end
        frame_valid = 1'b1;
        step();
        frame_valid = 1'b0;
        repeat (FRAME_GAP - 1) step();
    endtask

    // Wait for all expected results, bounded
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 64) begin
            step();
            waited++;
        end
        if (exp_q.size() > 0) begin
            err_count++;
            $display("%s: %0d expected avg results never arrived", cur_test, exp_q.size());
            exp_q.delete();
        end
        // Room for stray outputs to show up
        repeat (4) step();
    endtask

    task automatic read_check(int c);
        rd_en = 1'b1;
        rd_chan = osf_pkg::chan_t'(c);
        step();
        rd_en = 1'b0;
        check_flag("rd_valid", 1'b1, rd_valid);
        check_sample($sformatf("rd_data ch%0d", c), store_val[c], rd_data);
        check_flag($sformatf("rd_fresh ch%0d", c), store_fresh[c], rd_fresh);
        store_fresh[c] = 1'b0;
    endtask

    task automatic run_test(int t);
        int err_before;
        err_before = err_count;
        cur_test = tests[t].name;
        // Fresh groups on every channel
        for (int c = 0; c < N_CHAN; c++) begin
            clear_chan(c);
        end
        for (int c = 0; c < N_CHAN; c++) begin
            write_reg(`OSF_ADDR_OS, osf_pkg::reg_addr_t'(c), tests[t].os[c]);
            model_os[c] = int'(tests[t].os[c]);
        end
        // Low bits alias channel 0
        if (tests[t].bad_wr) begin
            write_reg(`OSF_ADDR_OS, 16'h0008, '0);
            write_reg(`OSF_ADDR_OS, 16'h0100, '0);
        end
        for (int f = 0; f < tests[t].frames; f++) begin
            if (f == tests[t].clr_frame && tests[t].clr_chan >= 0) begin
                repeat (4) step();
                clear_chan(tests[t].clr_chan);
            end
            send_frame(t, f);
        end
        wait_drain();
        // Second read of each channel sees fresh cleared
        if (tests[t].readback) begin
            for (int c = 0; c < N_CHAN; c++) begin
                read_check(c);
                read_check(c);
            end
        end
        $display("test %-9s %s, %0d errors", cur_test,
                 (err_count == err_before) ? "passed" : "failed", err_count - err_before);
    endtask

    // ----------------------------------------------------------
    // Output monitor
    // ----------------------------------------------------------
    always @(negedge clk_in) begin
        if (arst_n && avg.valid) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("%s: unexpected avg output on channel %0d with data %0d",
                         cur_test, avg.chan, avg.data);
            end else begin
                check_avg(exp_q.pop_front(), avg);
            end
        end
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the run did not complete", watchdog_ns);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int total_frames;
        frame_valid = 1'b0;
        frame = '0;
        reg_wr = '0;
        rd_en = 1'b0;
        rd_chan = '0;
        for (int c = 0; c < N_CHAN; c++) begin
            model_sum[c] = 0;
            model_cnt[c] = 0;
            model_os[c] = 0;
            store_val[c] = '0;
            store_fresh[c] = 1'b0;
        end
        // Read-back first, so channels 3 and 7 are still unwritten
        tests[0] = '{"readback", {3'd7, 3'd2, 3'd1, 3'd0, 3'd3, 3'd2, 3'd1, 3'd0},
                     4, PAT_RAMP, 100, -1, 0, 1'b0, 1'b1};
        tests[1] = '{"passthru", '0, 3, PAT_RAND, 0, -1, 0, 1'b0, 1'b0};
        tests[2] = '{"pow2_avg", {3'd3, 3'd2, 3'd1, 3'd4, 3'd0, 3'd3, 3'd2, 3'd1},
                     16, PAT_RAMP, -500, -1, 0, 1'b0, 1'b0};
        tests[3] = '{"sat_pos", {8{3'd7}}, 128, PAT_CONST, 131071, -1, 0, 1'b0, 1'b0};
        tests[4] = '{"sat_neg", {8{3'd7}}, 128, PAT_CONST, -131072, -1, 0, 1'b0, 1'b0};
        tests[5] = '{"clear", {8{3'd2}}, 8, PAT_RAND, 0, 3, 2, 1'b0, 1'b0};
        tests[6] = '{"bad_wr", {8{3'd1}}, 6, PAT_RAMP, 2000, 9, 1, 1'b1, 1'b1};
        // Frame time plus per-test setup, drain and reads
        total_frames = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total_frames += tests[t].frames;
        end
        watchdog_ns = longint'(total_frames * FRAME_GAP + N_TESTS * 200 + 20) * 8;
        wait (arst_n);
        step();
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS, check_count, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
src/osf_pkg.sv
src/frame_serializer.sv
src/chan_config_regs.sv
src/oversample_filter.sv
src/result_store.sv
src/osf_top.sv
testbench/tb_clock_gen.sv
testbench/osf_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= osf_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
